/* source/rename_settings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// architectural and physical register file sizes
`define NUM_LREG 32
`define NUM_PREG 64
`define LREG_WIDTH 5
`define PREG_WIDTH 6

// the free list holds every physical register that is not mapped at reset
`define FREE_DEPTH 32

`endif

/* source/rename_pkg.sv */
`include "rename_settings.svh"

package rename_pkg;

    typedef logic [`LREG_WIDTH-1:0] lreg_t;
    typedef logic [`PREG_WIDTH-1:0] preg_t;

    // occupancy needs one more code than the ring has entries
    typedef logic [$clog2(`FREE_DEPTH+1)-1:0] free_count_t;
    typedef logic [$clog2(`FREE_DEPTH)-1:0] free_ptr_t;

    typedef enum logic {
        FILL,
        RUN
    } rename_state_t;

endpackage

/* source/free_list_if.sv */
`timescale 1ns/100ps

interface free_list_if;
    import rename_pkg::*;

    logic fill;
    logic alloc0;
    logic alloc1;
    preg_t alloc_preg0;
    preg_t alloc_preg1;
    logic release_valid;
    preg_t release_preg;
    free_ptr_t head;
    free_ptr_t tail;
    free_count_t free_count;

    modport control (
        output fill, alloc0, alloc1,
        input free_count
    );

    modport ptrs (
        input fill, alloc0, alloc1, release_valid,
        output head, tail, free_count
    );

    modport storage (
        input fill, alloc0, release_valid, release_preg, head, tail,
        output alloc_preg0, alloc_preg1
    );

    modport table_side (
        input alloc_preg0, alloc_preg1
    );

endinterface

/* source/rename_control.sv */
`timescale 1ns/100ps
`include "rename_settings.svh"

module rename_control (
    input logic clock,
    input logic reset_n,
    input logic in_valid,
    input logic need_to_wb0,
    input logic need_to_wb1,
    output logic ready,
    output logic fire,
    free_list_if.control fl
);
    import rename_pkg::*;

    rename_state_t state;
    logic [1:0] wb_needed;

    // leave FILL on the edge that pushes the last free register
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= FILL;
        end else if (state == FILL && fl.free_count == free_count_t'(`FREE_DEPTH - 1)) begin
            state <= RUN;
        end
    end

    assign fl.fill = (state == FILL);

    assign wb_needed = {1'b0, need_to_wb0} + {1'b0, need_to_wb1};

    // stall when the group needs more registers than are free
    assign ready = (state == RUN) && (fl.free_count >= free_count_t'(wb_needed));
    assign fire = in_valid && ready;

    assign fl.alloc0 = fire && need_to_wb0;
    assign fl.alloc1 = fire && need_to_wb1;

endmodule

/* source/free_list_ptrs.sv */
`timescale 1ns/100ps

module free_list_ptrs (
    input logic clock,
    input logic reset_n,
    free_list_if.ptrs fl
);
    import rename_pkg::*;

    logic push;
    logic [1:0] pop_count;

    // commit releases are not expected while the list is being filled
    assign push = fl.fill || fl.release_valid;
    assign pop_count = {1'b0, fl.alloc0} + {1'b0, fl.alloc1};

    // the pointers wrap on their own width, which matches the ring depth
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fl.head <= '0;
        end else begin
            fl.head <= fl.head + free_ptr_t'(pop_count);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fl.tail <= '0;
        end else if (push) begin
            fl.tail <= fl.tail + free_ptr_t'(1);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fl.free_count <= '0;
        end else begin
            fl.free_count <= fl.free_count + free_count_t'(push) - free_count_t'(pop_count);
        end
    end

endmodule

/* source/free_list.sv */
`timescale 1ns/100ps
`include "rename_settings.svh"

module free_list (
    input logic clock,
    input logic reset_n,
    free_list_if.storage fl
);
    import rename_pkg::*;

    preg_t ring [0:`FREE_DEPTH-1];
    free_ptr_t head_plus1;
    preg_t fill_preg;
    preg_t wdata;

    assign head_plus1 = fl.head + free_ptr_t'(1);

    // slot 1 takes the second entry only when slot 0 also pops
    assign fl.alloc_preg0 = ring[fl.head];
    assign fl.alloc_preg1 = fl.alloc0 ? ring[head_plus1] : ring[fl.head];

    // the registers above the architectural ones start out free
    assign fill_preg = preg_t'(`NUM_PREG - `FREE_DEPTH + fl.tail);
    assign wdata = fl.fill ? fill_preg : fl.release_preg;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                ring[i] <= '0;
            end
        end else if (fl.fill || fl.release_valid) begin
            ring[fl.tail] <= wdata;
        end
    end

endmodule

/* source/rename_table.sv */
`timescale 1ns/100ps
`include "rename_settings.svh"

module rename_table (
    input logic clock,
    input logic reset_n,
    input logic fire,

    input logic instr0_src1_is_reg,
    input rename_pkg::lreg_t instr0_lrs1,
    input logic instr0_src2_is_reg,
    input rename_pkg::lreg_t instr0_lrs2,
    input logic instr0_need_to_wb,
    input rename_pkg::lreg_t instr0_lrd,

    input logic instr1_src1_is_reg,
    input rename_pkg::lreg_t instr1_lrs1,
    input logic instr1_src2_is_reg,
    input rename_pkg::lreg_t instr1_lrs2,
    input logic instr1_need_to_wb,
    input rename_pkg::lreg_t instr1_lrd,

    output rename_pkg::preg_t instr0_rat_prs1,
    output rename_pkg::preg_t instr0_rat_prs2,
    output rename_pkg::preg_t instr0_rat_prd,

    output rename_pkg::preg_t instr1_rat_prs1,
    output rename_pkg::preg_t instr1_rat_prs2,
    output rename_pkg::preg_t instr1_rat_prd,

    free_list_if.table_side fl
);
    import rename_pkg::*;

    preg_t map [0:`NUM_LREG-1];

    // disabled reads return physical register zero
    assign instr0_rat_prs1 = instr0_src1_is_reg ? map[instr0_lrs1] : '0;
    assign instr0_rat_prs2 = instr0_src2_is_reg ? map[instr0_lrs2] : '0;
    assign instr0_rat_prd = instr0_need_to_wb ? map[instr0_lrd] : '0;

    assign instr1_rat_prs1 = instr1_src1_is_reg ? map[instr1_lrs1] : '0;
    assign instr1_rat_prs2 = instr1_src2_is_reg ? map[instr1_lrs2] : '0;
    assign instr1_rat_prd = instr1_need_to_wb ? map[instr1_lrd] : '0;

    // slot 1 is written last so it is the one that sticks on a shared lrd
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_LREG; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (fire) begin
            if (instr0_need_to_wb) begin
                map[instr0_lrd] <= fl.alloc_preg0;
            end
            if (instr1_need_to_wb) begin
                map[instr1_lrd] <= fl.alloc_preg1;
            end
        end
    end

endmodule

/* source/rename_bypass.sv */
`timescale 1ns/100ps

module rename_bypass (
    input logic clock,
    input logic reset_n,
    input logic fire,

    input logic instr0_need_to_wb,
    input rename_pkg::lreg_t instr0_lrd,
    input logic instr1_src1_is_reg,
    input rename_pkg::lreg_t instr1_lrs1,
    input logic instr1_src2_is_reg,
    input rename_pkg::lreg_t instr1_lrs2,
    input logic instr1_need_to_wb,
    input rename_pkg::lreg_t instr1_lrd,

    input rename_pkg::preg_t instr0_rat_prs1,
    input rename_pkg::preg_t instr0_rat_prs2,
    input rename_pkg::preg_t instr0_rat_prd,
    input rename_pkg::preg_t instr1_rat_prs1,
    input rename_pkg::preg_t instr1_rat_prs2,
    input rename_pkg::preg_t instr1_rat_prd,
    input rename_pkg::preg_t alloc_preg0,
    input rename_pkg::preg_t alloc_preg1,

    output logic out_valid,
    output rename_pkg::preg_t instr0_prs1,
    output rename_pkg::preg_t instr0_prs2,
    output rename_pkg::preg_t instr0_prd,
    output rename_pkg::preg_t instr0_old_prd,
    output rename_pkg::preg_t instr1_prs1,
    output rename_pkg::preg_t instr1_prs2,
    output rename_pkg::preg_t instr1_prd,
    output rename_pkg::preg_t instr1_old_prd
);
    import rename_pkg::*;

    logic hit_src1;
    logic hit_src2;
    logic hit_lrd;

    // slot 1 sees slot 0's destination before the table does
    assign hit_src1 = instr1_src1_is_reg && instr0_need_to_wb && (instr1_lrs1 == instr0_lrd);
    assign hit_src2 = instr1_src2_is_reg && instr0_need_to_wb && (instr1_lrs2 == instr0_lrd);
    assign hit_lrd = instr1_need_to_wb && instr0_need_to_wb && (instr1_lrd == instr0_lrd);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            instr0_prs1 <= instr0_rat_prs1;
            instr0_prs2 <= instr0_rat_prs2;
            instr0_prd <= instr0_need_to_wb ? alloc_preg0 : '0;
            instr0_old_prd <= instr0_rat_prd;
            instr1_prs1 <= hit_src1 ? alloc_preg0 : instr1_rat_prs1;
            instr1_prs2 <= hit_src2 ? alloc_preg0 : instr1_rat_prs2;
            instr1_prd <= instr1_need_to_wb ? alloc_preg1 : '0;
            instr1_old_prd <= hit_lrd ? alloc_preg0 : instr1_rat_prd;
        end
    end

endmodule

/* source/rename_stage.sv */
`timescale 1ns/100ps

module rename_stage (
    input logic clock,
    input logic reset_n,
    input logic in_valid,
    output logic ready,

    input logic instr0_src1_is_reg,
    input rename_pkg::lreg_t instr0_lrs1,
    input logic instr0_src2_is_reg,
    input rename_pkg::lreg_t instr0_lrs2,
    input logic instr0_need_to_wb,
    input rename_pkg::lreg_t instr0_lrd,

    input logic instr1_src1_is_reg,
    input rename_pkg::lreg_t instr1_lrs1,
    input logic instr1_src2_is_reg,
    input rename_pkg::lreg_t instr1_lrs2,
    input logic instr1_need_to_wb,
    input rename_pkg::lreg_t instr1_lrd,

    input logic release_valid,
    input rename_pkg::preg_t release_preg,

    output logic out_valid,
    output rename_pkg::preg_t instr0_prs1,
    output rename_pkg::preg_t instr0_prs2,
    output rename_pkg::preg_t instr0_prd,
    output rename_pkg::preg_t instr0_old_prd,
    output rename_pkg::preg_t instr1_prs1,
    output rename_pkg::preg_t instr1_prs2,
    output rename_pkg::preg_t instr1_prd,
    output rename_pkg::preg_t instr1_old_prd
);
    import rename_pkg::*;

    logic fire;
    preg_t instr0_rat_prs1;
    preg_t instr0_rat_prs2;
    preg_t instr0_rat_prd;
    preg_t instr1_rat_prs1;
    preg_t instr1_rat_prs2;
    preg_t instr1_rat_prd;

    free_list_if fl ();

    assign fl.release_valid = release_valid;
    assign fl.release_preg = release_preg;

    rename_control u_control (
        .clock(clock),
        .reset_n(reset_n),
        .in_valid(in_valid),
        .need_to_wb0(instr0_need_to_wb),
        .need_to_wb1(instr1_need_to_wb),
        .ready(ready),
        .fire(fire),
        .fl(fl.control)
    );

    free_list_ptrs u_ptrs (
        .clock(clock),
        .reset_n(reset_n),
        .fl(fl.ptrs)
    );

    free_list u_free_list (
        .clock(clock),
        .reset_n(reset_n),
        .fl(fl.storage)
    );

    rename_table u_table (
        .clock(clock),
        .reset_n(reset_n),
        .fire(fire),
        .instr0_src1_is_reg(instr0_src1_is_reg),
        .instr0_lrs1(instr0_lrs1),
        .instr0_src2_is_reg(instr0_src2_is_reg),
        .instr0_lrs2(instr0_lrs2),
        .instr0_need_to_wb(instr0_need_to_wb),
        .instr0_lrd(instr0_lrd),
        .instr1_src1_is_reg(instr1_src1_is_reg),
        .instr1_lrs1(instr1_lrs1),
        .instr1_src2_is_reg(instr1_src2_is_reg),
        .instr1_lrs2(instr1_lrs2),
        .instr1_need_to_wb(instr1_need_to_wb),
        .instr1_lrd(instr1_lrd),
        .instr0_rat_prs1(instr0_rat_prs1),
        .instr0_rat_prs2(instr0_rat_prs2),
        .instr0_rat_prd(instr0_rat_prd),
        .instr1_rat_prs1(instr1_rat_prs1),
        .instr1_rat_prs2(instr1_rat_prs2),
        .instr1_rat_prd(instr1_rat_prd),
        .fl(fl.table_side)
    );

    rename_bypass u_bypass (
        .clock(clock),
        .reset_n(reset_n),
        .fire(fire),
        .instr0_need_to_wb(instr0_need_to_wb),
        .instr0_lrd(instr0_lrd),
        .instr1_src1_is_reg(instr1_src1_is_reg),
        .instr1_lrs1(instr1_lrs1),
        .instr1_src2_is_reg(instr1_src2_is_reg),
        .instr1_lrs2(instr1_lrs2),
        .instr1_need_to_wb(instr1_need_to_wb),
        .instr1_lrd(instr1_lrd),
        .instr0_rat_prs1(instr0_rat_prs1),
        .instr0_rat_prs2(instr0_rat_prs2),
        .instr0_rat_prd(instr0_rat_prd),
        .instr1_rat_prs1(instr1_rat_prs1),
        .instr1_rat_prs2(instr1_rat_prs2),
        .instr1_rat_prd(instr1_rat_prd),
        .alloc_preg0(fl.alloc_preg0),
        .alloc_preg1(fl.alloc_preg1),
        .out_valid(out_valid),
        .instr0_prs1(instr0_prs1),
        .instr0_prs2(instr0_prs2),
        .instr0_prd(instr0_prd),
        .instr0_old_prd(instr0_old_prd),
        .instr1_prs1(instr1_prs1),
        .instr1_prs2(instr1_prs2),
        .instr1_prd(instr1_prd),
        .instr1_old_prd(instr1_old_prd)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // reset is released on a falling edge, away from the edge the design samples on
    initial begin
        reset_n = 1'b0;
        repeat (8) @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

/* sim/rename_stage_checker.sv */
`timescale 1ns/100ps
`include "rename_settings.svh"

module rename_stage_checker (
    input logic clock,
    input logic reset_n,
    input logic in_valid,
    input logic ready,
    input logic out_valid,
    input rename_pkg::free_count_t free_count
);
    import rename_pkg::*;

    logic filled;

    // set once the free list has held every spare register
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            filled <= 1'b0;
        end else if (free_count == free_count_t'(`FREE_DEPTH)) begin
            filled <= 1'b1;
        end
    end

    // results come out exactly one cycle after a group is taken
    taken_gives_result: assert property (@(posedge clock) disable iff (!reset_n)
        (in_valid && ready) |=> out_valid)
        else $error("out_valid missing one cycle after a group was taken");

    result_needs_group: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid |-> $past(in_valid && ready))
        else $error("out_valid high without a group taken the cycle before");

    no_ready_in_fill: assert property (@(posedge clock) disable iff (!reset_n)
        ready |-> (filled || free_count == free_count_t'(`FREE_DEPTH)))
        else $error("ready high before the free list was filled");

    count_in_range: assert property (@(posedge clock)
        free_count <= free_count_t'(`FREE_DEPTH))
        else $error("free list occupancy above its depth");

endmodule

/* sim/rename_stage_tb.sv */
`timescale 1ns/100ps
`include "rename_settings.svh"

module rename_stage_tb;
    import rename_pkg::*;

    typedef struct packed {
        logic src1_is_reg;
        lreg_t lrs1;
        logic src2_is_reg;
        lreg_t lrs2;
        logic need_to_wb;
        lreg_t lrd;
    } slot_t;

    // a row is applied for repeat_n cycles and random rows draw their own fields
    typedef struct packed {
        logic [15:0] repeat_n;
        logic in_valid;
        logic rel;
        logic rnd;
        slot_t s0;
        slot_t s1;
    } row_t;

    logic clock;
    logic reset_n;
    logic in_valid;
    logic ready;
    slot_t s0;
    slot_t s1;
    logic release_valid;
    preg_t release_preg;
    logic out_valid;
    preg_t instr0_prs1;
    preg_t instr0_prs2;
    preg_t instr0_prd;
    preg_t instr0_old_prd;
    preg_t instr1_prs1;
    preg_t instr1_prs2;
    preg_t instr1_prd;
    preg_t instr1_old_prd;

    row_t rows[$];
    preg_t model_map [0:`NUM_LREG-1];
    preg_t free_q[$];
    preg_t retired_q[$];
    preg_t expected [0:7];
    logic expect_valid;
    logic [15:0] lfsr_state;
    int error_count;
    int check_count;
    int cycle_count = 0;
    int cycle_limit;

    tb_clock u_clock (
        .clock(clock),
        .reset_n(reset_n)
    );

    rename_stage dut (
        .clock(clock),
        .reset_n(reset_n),
        .in_valid(in_valid),
        .ready(ready),
        .instr0_src1_is_reg(s0.src1_is_reg),
        .instr0_lrs1(s0.lrs1),
        .instr0_src2_is_reg(s0.src2_is_reg),
        .instr0_lrs2(s0.lrs2),
        .instr0_need_to_wb(s0.need_to_wb),
        .instr0_lrd(s0.lrd),
        .instr1_src1_is_reg(s1.src1_is_reg),
        .instr1_lrs1(s1.lrs1),
        .instr1_src2_is_reg(s1.src2_is_reg),
        .instr1_lrs2(s1.lrs2),
        .instr1_need_to_wb(s1.need_to_wb),
        .instr1_lrd(s1.lrd),
        .release_valid(release_valid),
        .release_preg(release_preg),
        .out_valid(out_valid),
        .instr0_prs1(instr0_prs1),
        .instr0_prs2(instr0_prs2),
        .instr0_prd(instr0_prd),
        .instr0_old_prd(instr0_old_prd),
        .instr1_prs1(instr1_prs1),
        .instr1_prs2(instr1_prs2),
        .instr1_prd(instr1_prd),
        .instr1_old_prd(instr1_old_prd)
    );

    bind rename_stage rename_stage_checker u_checker (
        .clock(clock),
        .reset_n(reset_n),
        .in_valid(in_valid),
        .ready(ready),
        .out_valid(out_valid),
        .free_count(fl.free_count)
    );

    function automatic slot_t make_slot(input int s1r, input int lrs1, input int s2r,
                                        input int lrs2, input int wb, input int lrd);
        slot_t s;
        s.src1_is_reg = (s1r != 0);
        s.lrs1 = lreg_t'(lrs1);
        s.src2_is_reg = (s2r != 0);
        s.lrs2 = lreg_t'(lrs2);
        s.need_to_wb = (wb != 0);
        s.lrd = lreg_t'(lrd);
        return s;
    endfunction

    function automatic void add_row(input int n, input int valid, input int rel, input int rnd,
                                    input slot_t a, input slot_t b);
        row_t r;
        r.repeat_n = 16'(n);
        r.in_valid = (valid != 0);
        r.rel = (rel != 0);
        r.rnd = (rnd != 0);
        r.s0 = a;
        r.s1 = b;
        rows.push_back(r);
    endfunction

    // galois form with the taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic slot_t random_slot();
        return make_slot(take_bits(1), take_bits(5), take_bits(1), take_bits(5),
                         take_bits(1), take_bits(5));
    endfunction

    function automatic void build_table();
        slot_t idle;
        slot_t g0;
        slot_t g1;
        idle = make_slot(0, 0, 0, 0, 0, 0);
        // the first group reads the identity mapping and gets 32 and 33
        add_row(1, 1, 0, 0, make_slot(1, 3, 1, 4, 1, 5), make_slot(1, 6, 1, 7, 1, 8));
        // gated sources and no write back give zero
        add_row(1, 1, 0, 0, make_slot(0, 3, 1, 9, 0, 10), make_slot(1, 11, 0, 12, 0, 13));
        add_row(1, 0, 0, 0, make_slot(1, 1, 1, 2, 1, 3), idle);
        // slot 1 reads what slot 0 writes
        add_row(1, 1, 0, 0, make_slot(1, 1, 1, 2, 1, 12), make_slot(1, 12, 1, 12, 1, 13));
        add_row(1, 1, 0, 0, make_slot(0, 0, 0, 0, 1, 14), make_slot(1, 14, 0, 0, 1, 14));
        add_row(1, 1, 0, 0, make_slot(1, 14, 1, 13, 0, 0), make_slot(1, 5, 1, 8, 0, 0));
        add_row(1, 1, 0, 0, make_slot(1, 2, 0, 0, 0, 3), make_slot(1, 3, 0, 0, 1, 15));
        // drain down to one free register
        add_row(12, 1, 0, 0, make_slot(1, 16, 1, 17, 1, 16), make_slot(1, 16, 1, 17, 1, 17));
        g0 = make_slot(1, 16, 0, 0, 1, 18);
        g1 = make_slot(1, 18, 0, 0, 1, 19);
        add_row(1, 1, 0, 0, g0, g1);
        add_row(1, 1, 1, 0, g0, g1);
        add_row(1, 1, 0, 0, g0, g1);
        add_row(2, 1, 1, 0, make_slot(1, 19, 0, 0, 1, 20), idle);
        add_row(4, 0, 1, 0, idle, idle);
        add_row(1, 1, 0, 0, make_slot(1, 20, 1, 18, 1, 21), make_slot(1, 21, 0, 0, 1, 22));
        add_row(400, 0, 0, 1, idle, idle);
    endfunction

    task automatic compare(input string name, input int expected_value, input int actual);
        check_count++;
        if (expected_value != actual) begin
            error_count++;
            $display("error at %0t: %s expected %0d, got %0d", $time, name,
                     expected_value, actual);
        end
    endtask

    task automatic check_outputs();
        compare("out_valid", int'(expect_valid), int'(out_valid));
        if (expect_valid) begin
            compare("instr0_prs1", int'(expected[0]), int'(instr0_prs1));
            compare("instr0_prs2", int'(expected[1]), int'(instr0_prs2));
            compare("instr0_prd", int'(expected[2]), int'(instr0_prd));
            compare("instr0_old_prd", int'(expected[3]), int'(instr0_old_prd));
            compare("instr1_prs1", int'(expected[4]), int'(instr1_prs1));
            compare("instr1_prs2", int'(expected[5]), int'(instr1_prs2));
            compare("instr1_prd", int'(expected[6]), int'(instr1_prd));
            compare("instr1_old_prd", int'(expected[7]), int'(instr1_old_prd));
        end
    endtask

    // slot 0 of a group renames before slot 1, as in program order
    task automatic predict(input logic valid, input slot_t a, input slot_t b,
                           output logic fired);
        int need;
        preg_t n0;
        preg_t n1;
        need = int'(a.need_to_wb) + int'(b.need_to_wb);
        compare("ready", int'(free_q.size() >= need), int'(ready));
        fired = valid && (free_q.size() >= need);
        if (fired) begin
            n0 = a.need_to_wb ? free_q.pop_front() : '0;
            n1 = b.need_to_wb ? free_q.pop_front() : '0;
            expected[0] = a.src1_is_reg ? model_map[a.lrs1] : '0;
            expected[1] = a.src2_is_reg ? model_map[a.lrs2] : '0;
            expected[2] = n0;
            expected[3] = a.need_to_wb ? model_map[a.lrd] : '0;
            if (a.need_to_wb) begin
                model_map[a.lrd] = n0;
                retired_q.push_back(expected[3]);
            end
            expected[4] = b.src1_is_reg ? model_map[b.lrs1] : '0;
            expected[5] = b.src2_is_reg ? model_map[b.lrs2] : '0;
            expected[6] = n1;
            expected[7] = b.need_to_wb ? model_map[b.lrd] : '0;
            if (b.need_to_wb) begin
                model_map[b.lrd] = n1;
                retired_q.push_back(expected[7]);
            end
        end
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        row_t r;
        logic fired;
        logic held;
        logic rel_now;
        slot_t hold0;
        slot_t hold1;
        int total;
        in_valid = 1'b0;
        s0 = '0;
        s1 = '0;
        release_valid = 1'b0;
        release_preg = '0;
        expect_valid = 1'b0;
        lfsr_state = 16'd44344;
        error_count = 0;
        check_count = 0;
        held = 1'b0;
        hold0 = '0;
        hold1 = '0;
        for (int i = 0; i < `NUM_LREG; i++) begin
            model_map[i] = preg_t'(i);
        end
        for (int i = 0; i < `FREE_DEPTH; i++) begin
            free_q.push_back(preg_t'(`NUM_LREG + i));
        end
        build_table();
        total = 0;
        for (int i = 0; i < rows.size(); i++) begin
            total = total + int'(rows[i].repeat_n);
        end
        cycle_limit = 32 + 8 + total * 4 + 100;

        // the stage refuses groups while the free list fills
        @(posedge reset_n);
        for (int k = 0; k < 32; k++) begin
            #2;
            compare("ready", 0, int'(ready));
            @(negedge clock);
        end

        for (int i = 0; i < rows.size(); i++) begin
            for (int n = 0; n < int'(rows[i].repeat_n); n++) begin
                check_outputs();
                r = rows[i];
                if (r.rnd && held) begin
                    // a stalled group stays on the inputs until it is taken
                    r.in_valid = 1'b1;
                    r.s0 = hold0;
                    r.s1 = hold1;
                end else if (r.rnd) begin
                    r.in_valid = (take_bits(2) != 0);
                    r.s0 = random_slot();
                    r.s1 = random_slot();
                end
                rel_now = r.rnd ? (take_bits(1) != 0) : r.rel;
                in_valid = r.in_valid;
                s0 = r.s0;
                s1 = r.s1;
                if (rel_now && retired_q.size() > 0) begin
                    release_valid = 1'b1;
                    release_preg = retired_q.pop_front();
                end else begin
                    release_valid = 1'b0;
                    release_preg = '0;
                end
                #2;
                predict(r.in_valid, r.s0, r.s1, fired);
                if (release_valid) begin
                    free_q.push_back(release_preg);
                end
                expect_valid = fired;
                held = r.in_valid && !fired;
                hold0 = r.s0;
                hold1 = r.s1;
                @(negedge clock);
            end
        end

        check_outputs();
        in_valid = 1'b0;
        release_valid = 1'b0;
        expect_valid = 1'b0;
        @(negedge clock);
        check_outputs();

        $display("rename stage: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/rename_pkg.sv
source/free_list_if.sv
source/rename_control.sv
source/free_list_ptrs.sv
source/free_list.sv
source/rename_table.sv
source/rename_bypass.sv
source/rename_stage.sv
sim/tb_clock.sv
sim/rename_stage_checker.sv
sim/rename_stage_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module rename_stage_tb -f sim.f -o rename_stage_sim
	./obj_dir/rename_stage_sim > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q '\*\*\* FAILED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
